//--- src/tapper_pkg.sv
package tapper_pkg;

    typedef logic [9:0]  coord_t;
    typedef logic [1:0]  row_t;
    typedef logic [23:0] color_t;
    typedef logic [7:0]  score_t;

    localparam int NUM_ROWS = 4;

    // Row tops, index 0 is the top row
    localparam coord_t [NUM_ROWS-1:0] ROW_Y = {10'd380, 10'd284, 10'd188, 10'd92};

    localparam coord_t PLAYER_X    = 10'd400; // Tap position
    localparam coord_t CUS_MIN_X   = 10'd60;
    localparam coord_t CUS_MAX_X   = 10'd380; // End of the bar
    localparam coord_t CUS_STEP    = 10'd2;
    localparam coord_t CUP_START_X = 10'd380;

    localparam int PLAYER_W  = 20;
    localparam int PLAYER_H  = 40;
    localparam int CUST_SIZE = 20;
    localparam int CUP_SIZE  = 10;

    localparam color_t PLAYER_COLOR = 24'h7F2B0A;
    localparam color_t CUST_COLOR   = 24'h00FF00;
    localparam color_t CUP_COLOR    = 24'h7F2B0A;

    // Tick periods in clocks
    localparam int MOVE_PERIOD = 8;
    localparam int CUP_PERIOD  = 4;
    localparam int CUST_PERIOD = 16;

    localparam logic [6:0] LFSR_SEED = 7'h32;

    typedef struct packed {
        logic serve;  // Strobe
        logic left;   // Level, sampled on move ticks
        logic up;     // Strobe
        logic down;   // Strobe
    } btn_t;

    typedef struct packed {
        logic   valid;
        coord_t x;
        coord_t y;
    } pix_req_t;

    typedef struct packed {
        coord_t                    player_x;
        row_t                      player_row;
        coord_t [NUM_ROWS-1:0]     cust_x;
        coord_t [NUM_ROWS-1:0]     cup_x;
        logic   [NUM_ROWS-1:0]     cup_active;
    } scene_t;

    typedef enum logic {
        CUP_IDLE,
        CUP_SLIDING
    } cup_state_t;

endpackage

//--- src/tick_timer.sv
`timescale 1ns/10ps

module tick_timer (
    input  logic clk,
    input  logic rst,
    output logic move_tick,
    output logic cup_tick,
    output logic cust_tick
);
    import tapper_pkg::*;

    logic [$clog2(MOVE_PERIOD)-1:0] move_cnt;
    logic [$clog2(CUP_PERIOD)-1:0]  cup_cnt;
    logic [$clog2(CUST_PERIOD)-1:0] cust_cnt;

    // Strobe on the last count of each period
    assign move_tick = (move_cnt == $bits(move_cnt)'(MOVE_PERIOD - 1));
    assign cup_tick  = (cup_cnt == $bits(cup_cnt)'(CUP_PERIOD - 1));
    assign cust_tick = (cust_cnt == $bits(cust_cnt)'(CUST_PERIOD - 1));

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            move_cnt <= '0;
            cup_cnt  <= '0;
            cust_cnt <= '0;
        end
        else
        begin
            move_cnt <= move_tick ? '0 : move_cnt + 1'b1;
            cup_cnt  <= cup_tick ? '0 : cup_cnt + 1'b1;
            cust_cnt <= cust_tick ? '0 : cust_cnt + 1'b1;
        end
    end

    // Each tick is a single-cycle strobe
    a_tick_single: assert property (@(posedge clk) disable iff (!rst)
        (move_tick |=> !move_tick) and (cup_tick |=> !cup_tick) and (cust_tick |=> !cust_tick));

endmodule

//--- src/player_ctrl.sv
`timescale 1ns/10ps

module player_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  tapper_pkg::btn_t    btn,
    input  logic                move_tick,
    output tapper_pkg::coord_t  player_x,
    output tapper_pkg::row_t    player_row
);
    import tapper_pkg::*;

    // Row select, wraps at both ends of the bar stack
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            player_row <= '0;
        end
        else if (btn.up)
        begin
            player_row <= player_row - 1'b1; // 0 wraps to 3
        end
        else if (btn.down)
        begin
            player_row <= player_row + 1'b1; // 3 wraps to 0
        end
    end

    // Walk left while held, snap back to the tap on release
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            player_x <= PLAYER_X;
        end
        else if (move_tick)
        begin
            if (btn.left)
            begin
                if (player_x > '0)
                begin
                    player_x <= player_x - 1'b1;
                end
            end
            else
            begin
                player_x <= PLAYER_X;
            end
        end
    end

    // Bartender never goes right of the tap
    a_player_x_range: assert property (@(posedge clk) disable iff (!rst)
        player_x <= PLAYER_X);

endmodule

//--- src/cup_lane.sv
`timescale 1ns/10ps

module cup_lane #(
    parameter int LANE = 0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               serve,
    input  logic               cup_tick,
    input  tapper_pkg::row_t   player_row,
    input  tapper_pkg::coord_t cust_x,
    output tapper_pkg::coord_t cup_x,
    output logic               cup_active,
    output logic               served
);
    import tapper_pkg::*;

    cup_state_t state;

    assign cup_active = (state == CUP_SLIDING);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state  <= CUP_IDLE;
            cup_x  <= CUP_START_X;
            served <= 1'b0;
        end
        else
        begin
            served <= 1'b0; // Pulse only
            case (state)
                CUP_IDLE:
                begin
                    if (serve && player_row == row_t'(LANE))
                    begin
                        cup_x <= CUP_START_X;
                        state <= CUP_SLIDING;
                    end
                end
                CUP_SLIDING:
                begin
                    if (cup_tick)
                    begin
                        if (cup_x <= cust_x) // Reached this lane's customer
                        begin
                            served <= 1'b1;
                            cup_x  <= CUP_START_X;
                            state  <= CUP_IDLE;
                        end
                        else
                        begin
                            cup_x <= cup_x - 1'b1;
                        end
                    end
                end
                default: state <= CUP_IDLE;
            endcase
        end
    end

    // A delivery pulse must follow a cycle spent sliding
    a_served_from_slide: assert property (@(posedge clk) disable iff (!rst)
        served |-> $past(state) == CUP_SLIDING);

endmodule

//--- src/customer_line.sv
`timescale 1ns/10ps

module customer_line (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          cust_tick,
    input  logic [tapper_pkg::NUM_ROWS-1:0]               served,
    output tapper_pkg::coord_t [tapper_pkg::NUM_ROWS-1:0] cust_x,
    output tapper_pkg::score_t                            score
);
    import tapper_pkg::*;

    logic [6:0] lfsr;
    logic [2:0] pick;

    assign pick = lfsr[2:0]; // Lane k moves when pick is k+1

    // x^7 + x^6 + 1, Fibonacci form
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            lfsr <= LFSR_SEED;
        end
        else
        begin
            lfsr <= {lfsr[5:0], lfsr[6] ^ lfsr[5]};
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            for (int k = 0; k < NUM_ROWS; k++)
            begin
                cust_x[k] <= CUS_MIN_X;
            end
        end
        else
        begin
            for (int k = 0; k < NUM_ROWS; k++)
            begin
                if (served[k])
                begin
                    cust_x[k] <= CUS_MIN_X; // Back to the door
                end
                else if (cust_tick)
                begin
                    if (cust_x[k] >= CUS_MAX_X)
                        cust_x[k] <= CUS_MIN_X;
                    else if (pick == 3'(k + 1))
                        cust_x[k] <= cust_x[k] + CUS_STEP;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            score <= '0;
        else
            score <= score + score_t'($countones(served)); // Several lanes may land at once
    end

endmodule

//--- src/sprite_render.sv
`timescale 1ns/10ps

module sprite_render (
    input  logic                 clk,
    input  logic                 rst,
    input  tapper_pkg::pix_req_t pix_req,
    input  tapper_pkg::scene_t   scene,
    output logic                 pix_write,
    output tapper_pkg::color_t   pix_color
);
    import tapper_pkg::*;

    logic   hit;
    color_t hit_color;

    // Box test in 11 bits so the right and bottom edges cannot wrap
    function automatic logic in_box(coord_t px, coord_t py, coord_t bx, coord_t by,
                                    int w, int h);
        logic [10:0] right;
        logic [10:0] bottom;
        right  = {1'b0, bx} + 11'(w);
        bottom = {1'b0, by} + 11'(h);
        return (px >= bx) && ({1'b0, px} < right) && (py >= by) && ({1'b0, py} < bottom);
    endfunction

    // Player first, then customers, then active cups
    always_comb
    begin
        hit       = 1'b0;
        hit_color = '0;
        if (in_box(pix_req.x, pix_req.y, scene.player_x, ROW_Y[scene.player_row],
                   PLAYER_W, PLAYER_H))
        begin
            hit       = 1'b1;
            hit_color = PLAYER_COLOR;
        end
        for (int k = 0; k < NUM_ROWS; k++)
        begin
            if (!hit && in_box(pix_req.x, pix_req.y, scene.cust_x[k], ROW_Y[k],
                               CUST_SIZE, CUST_SIZE))
            begin
                hit       = 1'b1;
                hit_color = CUST_COLOR;
            end
        end
        for (int k = 0; k < NUM_ROWS; k++)
        begin
            if (!hit && scene.cup_active[k] &&
                in_box(pix_req.x, pix_req.y, scene.cup_x[k], ROW_Y[k], CUP_SIZE, CUP_SIZE))
            begin
                hit       = 1'b1;
                hit_color = CUP_COLOR;
            end
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            pix_write <= 1'b0;
        else
            pix_write <= pix_req.valid && hit;
    end

    always_ff @(posedge clk)
    begin
        pix_color <= hit_color;
    end

endmodule

//--- src/tapper_top.sv
`timescale 1ns/10ps

module tapper_top (
    input  logic                 clk,
    input  logic                 rst,
    input  tapper_pkg::btn_t     btn,
    input  tapper_pkg::pix_req_t pix_req,
    output logic                 pix_write,
    output tapper_pkg::color_t   pix_color,
    output tapper_pkg::score_t   score
);
    import tapper_pkg::*;

    logic move_tick, cup_tick, cust_tick;

    coord_t                player_x;
    row_t                  player_row;
    coord_t [NUM_ROWS-1:0] cust_x;
    coord_t [NUM_ROWS-1:0] cup_x;
    logic   [NUM_ROWS-1:0] cup_active;
    logic   [NUM_ROWS-1:0] served;
    scene_t                scene;

    tick_timer tick_timer_i (.clk, .rst, .move_tick, .cup_tick, .cust_tick);

    player_ctrl player_ctrl_i (.clk, .rst, .btn, .move_tick, .player_x, .player_row);

    for (genvar g = 0; g < NUM_ROWS; g++)
    begin : g_lane
        cup_lane #(.LANE(g)) cup_lane_i (
            .clk, .rst,
            .serve      (btn.serve),
            .cup_tick,
            .player_row,
            .cust_x     (cust_x[g]),  // Each lane watches its own customer
            .cup_x      (cup_x[g]),
            .cup_active (cup_active[g]),
            .served     (served[g])
        );
    end

    customer_line customer_line_i (.clk, .rst, .cust_tick, .served, .cust_x, .score);

    assign scene = '{player_x: player_x, player_row: player_row, cust_x: cust_x,
                     cup_x: cup_x, cup_active: cup_active};

    sprite_render sprite_render_i (.clk, .rst, .pix_req, .scene, .pix_write, .pix_color);

endmodule

//--- testbench/tb_tapper.sv
`timescale 1ns/10ps

module tb_tapper;
    import tapper_pkg::*;

    localparam int   RANDOM_CYCLES = 24000;
    localparam int   SCRIPT_CYCLES = RANDOM_CYCLES + 1500; // Delivery takes about 1300
    localparam btn_t SERVE = 4'b1000;
    localparam btn_t UP    = 4'b0010;
    localparam btn_t DOWN  = 4'b0001;

    logic        clk = 1'b0;
    logic        rst;
    btn_t        btn;
    pix_req_t    pix_req;
    logic        pix_write;
    color_t      pix_color;
    score_t      score;
    logic [31:0] rng = 32'haee8daf6;

    // Reference model state
    int                  m_cnt [3];
    logic [6:0]          m_lfsr;
    coord_t              m_px;
    row_t                m_row;
    coord_t              m_cust [NUM_ROWS];
    coord_t              m_cup [NUM_ROWS];
    logic [NUM_ROWS-1:0] m_slide;
    logic [NUM_ROWS-1:0] m_served;
    score_t              m_score;
    logic                m_write;
    color_t              m_color;

    tapper_top dut_i (.clk, .rst, .btn, .pix_req, .pix_write, .pix_color, .score);

    always #20 clk = ~clk;

    // Taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb  = rng[31] ^ rng[21] ^ rng[1] ^ rng[0];
            rng = {rng[30:0], fb};
            r   = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic inside_box(int px, int py, int bx, int by, int w, int h);
        return px >= bx && px < bx + w && py >= by && py < by + h;
    endfunction

    task automatic stop_run(string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp)
        else stop_run($sformatf("[ERROR] %s is %0h, expected %0h", name, got, exp));
    endtask

    function automatic void reset_model();
        m_cnt    = '{0, 0, 0};
        m_lfsr   = LFSR_SEED;
        m_px     = PLAYER_X;
        m_row    = '0;
        m_slide  = '0;
        m_served = '0;
        m_score  = '0;
        m_write  = 1'b0;
        for (int k = 0; k < NUM_ROWS; k++)
        begin
            m_cust[k] = CUS_MIN_X;
            m_cup[k]  = CUP_START_X;
        end
    endfunction

    // One clock of the game rules
    function automatic void step_model(btn_t b, pix_req_t q);
        logic [NUM_ROWS-1:0] done;
        logic [2:0]          pick;
        logic                mv;
        logic                cp;
        logic                ct;
        logic                hit;
        mv      = m_cnt[0] == MOVE_PERIOD - 1;
        cp      = m_cnt[1] == CUP_PERIOD - 1;
        ct      = m_cnt[2] == CUST_PERIOD - 1;
        pick    = m_lfsr[2:0];
        done    = m_served;
        hit     = inside_box(q.x, q.y, m_px, ROW_Y[m_row], PLAYER_W, PLAYER_H);
        m_color = PLAYER_COLOR;
        for (int k = 0; k < NUM_ROWS; k++)
        begin
            if (!hit && inside_box(q.x, q.y, m_cust[k], ROW_Y[k], CUST_SIZE, CUST_SIZE))
            begin
                hit     = 1'b1;
                m_color = CUST_COLOR;
            end
        end
        for (int k = 0; k < NUM_ROWS; k++)
        begin
            if (!hit && m_slide[k] && inside_box(q.x, q.y, m_cup[k], ROW_Y[k], CUP_SIZE, CUP_SIZE))
            begin
                hit     = 1'b1;
                m_color = CUP_COLOR;
            end
        end
        m_write = q.valid && hit;
        for (int k = 0; k < NUM_ROWS; k++)
        begin
            m_served[k] = 1'b0;
            if (!m_slide[k] && b.serve && m_row == row_t'(k))
            begin
                m_slide[k] = 1'b1;
                m_cup[k]   = CUP_START_X;
            end
            else if (m_slide[k] && cp && m_cup[k] <= m_cust[k])
            begin
                m_served[k] = 1'b1;
                m_slide[k]  = 1'b0;
                m_cup[k]    = CUP_START_X;
            end
            else if (m_slide[k] && cp)
                m_cup[k] = m_cup[k] - 10'd1;
            if (done[k])
                m_cust[k] = CUS_MIN_X;
            else if (ct && m_cust[k] >= CUS_MAX_X)
                m_cust[k] = CUS_MIN_X;
            else if (ct && pick == 3'(k + 1))
                m_cust[k] = m_cust[k] + CUS_STEP;
            m_score = m_score + score_t'(done[k]);
        end
        if (b.up)
            m_row = m_row - 2'd1;
        else if (b.down)
            m_row = m_row + 2'd1;
        if (mv && !b.left)
            m_px = PLAYER_X;
        else if (mv && m_px != 0)
            m_px = m_px - 10'd1;
        m_cnt[0] = mv ? 0 : m_cnt[0] + 1;
        m_cnt[1] = cp ? 0 : m_cnt[1] + 1;
        m_cnt[2] = ct ? 0 : m_cnt[2] + 1;
        m_lfsr   = {m_lfsr[5:0], m_lfsr[6] ^ m_lfsr[5]}; // x^7 + x^6 + 1
    endfunction

    always @(posedge clk or negedge rst)
    begin
        if (!rst)
            reset_model();
        else
            step_model(btn, pix_req);
    end

    // Outputs are stable half a period after the rising edge
    always @(negedge clk)
    begin
        if (rst)
        begin
            check_value("pix_write", pix_write, m_write);
            if (m_write)
                check_value("pix_color", pix_color, m_color);
            check_value("score", score, m_score);
        end
    end

    task automatic press(btn_t b);
        btn = b;
        @(negedge clk);
        btn = '0;
    endtask

    task automatic query(int x, int y, logic exp_w, color_t exp_c);
        pix_req = '{valid: 1'b1, x: coord_t'(x), y: coord_t'(y)};
        @(negedge clk);
        pix_req.valid = 1'b0;
        check_value("pix_write", pix_write, exp_w);
        if (exp_w)
            check_value("pix_color", pix_color, exp_c);
    endtask

    initial
    begin
        int     row;
        btn     = '0;
        pix_req = '0;
        rst     = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b1;
        query(PLAYER_X, ROW_Y[0], 1'b1, PLAYER_COLOR);
        for (int k = 0; k < NUM_ROWS; k++)
            query(CUS_MIN_X, ROW_Y[k], 1'b1, CUST_COLOR);
        query(200, 20, 1'b0, '0); // Empty floor
        check_value("score", score, 0);
        press(UP); // Row 0 wraps to 3
        query(PLAYER_X + 5, ROW_Y[3] + 5, 1'b1, PLAYER_COLOR);
        press(DOWN);
        query(PLAYER_X + 5, ROW_Y[0] + 5, 1'b1, PLAYER_COLOR);
        press(DOWN);
        query(PLAYER_X + 5, ROW_Y[1] + 5, 1'b1, PLAYER_COLOR);
        btn.left = 1'b1;
        repeat (3 * MOVE_PERIOD) @(negedge clk);
        query(PLAYER_X - 4, ROW_Y[1], 1'b0, '0); // Three steps, not four
        query(PLAYER_X - 3, ROW_Y[1], 1'b1, PLAYER_COLOR);
        btn.left = 1'b0;
        repeat (MOVE_PERIOD) @(negedge clk);
        query(PLAYER_X + PLAYER_W - 1, ROW_Y[1], 1'b1, PLAYER_COLOR); // Back at the tap
        press(SERVE);
        query(m_cup[1], ROW_Y[1] + 2, 1'b1, CUP_COLOR);
        repeat (2 * CUP_PERIOD) @(negedge clk);
        press(SERVE); // Lane busy, no relaunch
        query(CUP_START_X + CUP_SIZE - 1, ROW_Y[1], 1'b0, '0);
        while (score == 0)
            @(negedge clk);
        check_value("score", score, 8'd1);
        query(CUS_MIN_X + 1, ROW_Y[1] + 1, 1'b1, CUST_COLOR);
        for (int i = 0; i < RANDOM_CYCLES; i++)
        begin
            // Row 0 gets no serves here so its customer walks the whole bar and wraps
            btn = '{serve: take_bits(12) == 0 && m_row != 0, left: take_bits(1) != 0,
                    up: take_bits(6) == 0, down: take_bits(6) == 0};
            row = int'(take_bits(2));
            pix_req = '{valid: take_bits(1) != 0, x: coord_t'(take_bits(9)),
                        y: ROW_Y[row] + coord_t'(take_bits(5))};
            @(negedge clk);
        end
        btn     = '0;
        pix_req = '0;
        repeat (2) @(negedge clk);
        $display(">>> PASS");
        $finish;
    end

    initial
    begin
        #(2 * SCRIPT_CYCLES * 40);
        stop_run("Timeout, the run did not reach its end");
    end

endmodule

//--- src.f
src/tapper_pkg.sv
src/tick_timer.sv
src/player_ctrl.sv
src/cup_lane.sv
src/customer_line.sv
src/sprite_render.sv
src/tapper_top.sv
testbench/tb_tapper.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_tapper -f src.f
./obj_dir/Vtb_tapper | tee sim.log

if grep -qx ">>> PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
